// File: bench/ex_stage_sva.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage_sva (
  input logic clock,
  input logic reset_n,
  input logic issue_valid,
  input logic ex_mem_valid,
  input logic wb_valid,
  input logic new_pc_valid
);

  // Assertion failures so far
  int fail_count = 0;

  ex_mem_low_in_reset: assert property (@(posedge clock) !reset_n |-> !ex_mem_valid)
    else begin
      $error("ex_mem_valid high while in reset");
      fail_count++;
    end

  // wb stage is a plain copy of EX/MEM valid
  wb_follows_ex_mem: assert property (@(posedge clock) disable iff (!reset_n)
    wb_valid == $past(ex_mem_valid))
    else begin
      $error("wb_valid does not follow ex_mem_valid");
      fail_count++;
    end

  redirect_needs_issue: assert property (@(posedge clock) new_pc_valid |-> issue_valid)
    else begin
      $error("new_pc_valid without issue_valid");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: bench/ex_stage_tb.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage_tb import isa_pkg::*, pipe_pkg::*; ();

  logic                     clock;
  logic                     reset_n;
  logic                     issue_valid;
  alu_op_t                  alu_op;
  alu_res_t                 alu_res_sel;
  logic                     alu_set_u;
  muldiv_op_t               muldiv_op;
  logic                     muldiv_u;
  logic                     jmp_inst;
  logic                     branch_inst;
  cond_t                    branch_cond;
  logic [data_width-1:0]    imm;
  logic                     imm_valid;
  logic [4:0]               shamt;
  logic [reg_idx_width-1:0] a_reg;
  logic                     a_reg_valid;
  logic [reg_idx_width-1:0] b_reg;
  logic                     b_reg_valid;
  logic [data_width-1:0]    a_val;
  logic [data_width-1:0]    b_val;
  logic [reg_idx_width-1:0] dest_reg;
  logic                     dest_reg_valid;
  logic [data_width-1:0]    pc_plus_8;
  logic [data_width-1:0]    new_pc;
  logic                     new_pc_valid;
  logic [data_width-1:0]    result_2;
  logic [data_width-1:0]    ex_mem_result;
  logic [reg_idx_width-1:0] ex_mem_dest;
  logic                     ex_mem_valid;
  logic [data_width-1:0]    wb_result;
  logic [reg_idx_width-1:0] wb_dest;
  logic                     wb_valid;

  integer seed = 44114;
  int errors = 0;
  int checks = 0;
  int cnt;
  logic [31:0] shadow [32];
  logic [31:0] hi_m;
  logic [31:0] lo_m;
  logic [31:0] q_res[$];
  logic [4:0] q_dest[$];
  logic q_wr[$];

  tb_clock_gen clock_gen_inst (.clock(clock), .reset_n(reset_n));
  ex_stage ex_stage_inst (.*);
  bind ex_stage ex_stage_sva ex_stage_sva_inst (.*);

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [4:0] pick_reg();
    pick_reg = 5'(1 + ({$random(seed)} % 20));
  endfunction

  function automatic logic [31:0] model_alu(alu_op_t op, logic [31:0] a, logic [31:0] b,
      logic [31:0] bf, logic [4:0] sh, logic [31:0] iv, logic set_res, logic set_u);
    int lsb;
    int msb;
    logic [31:0] r;
    lsb = iv[10:6];
    msb = iv[15:11];
    if (set_res)
      return set_u ? {31'b0, a < b} : {31'b0, $signed(a) < $signed(b)};
    case (op)
      alu_add: r = a + b;
      alu_sub: r = a - b;
      alu_or: r = a | b;
      alu_xor: r = a ^ b;
      alu_nor: r = ~(a | b);
      alu_and: r = a & b;
      alu_pass_b: r = b;
      alu_sll: r = b << sh;
      alu_srl: r = b >> sh;
      alu_sra: r = $signed(b) >>> sh;
      alu_lui: r = b << 16;
      alu_seb: r = 32'($signed(b[7:0]));
      alu_seh: r = 32'($signed(b[15:0]));
      alu_ext: begin
        r = '0;
        for (int i = 0; i < 32; i++)
          if (i <= msb && i + lsb < 32) r[i] = a[i + lsb];
      end
      alu_ins: begin
        r = bf;
        for (int i = 0; i < 32; i++)
          if (i >= lsb && i <= msb) r[i] = a[i - lsb];
      end
      alu_mul_lo: r = a * b;
      default: r = a;
    endcase
    return r;
  endfunction

  task automatic cycle();
    @(posedge clock);
    #1;
    if (q_wr.size() >= 1) begin
      check("ex_mem_valid", ex_mem_valid, q_wr[$]);
      if (q_wr[$]) begin
        check("ex_mem_result", ex_mem_result, q_res[$]);
        check("ex_mem_dest", ex_mem_dest, q_dest[$]);
      end
    end
    if (q_wr.size() >= 2) begin
      check("wb_valid", wb_valid, q_wr[0]);
      if (q_wr[0]) begin
        check("wb_result", wb_result, q_res[0]);
        check("wb_dest", wb_dest, q_dest[0]);
      end
      void'(q_wr.pop_front());
      void'(q_res.pop_front());
      void'(q_dest.pop_front());
    end
  endtask

  task automatic clear();
    issue_valid = 0;
    alu_op = alu_add;
    alu_res_sel = res_alu;
    alu_set_u = 0;
    muldiv_op = md_none;
    muldiv_u = 0;
    jmp_inst = 0;
    branch_inst = 0;
    branch_cond = cond_unconditional;
    imm = '0;
    imm_valid = 0;
    shamt = '0;
    a_reg = '0;
    a_reg_valid = 0;
    b_reg = '0;
    b_reg_valid = 0;
    dest_reg = '0;
    dest_reg_valid = 0;
    pc_plus_8 = '0;
  endtask

  task automatic idle();
    clear();
    q_wr.push_back(1'b0);
    q_res.push_back('0);
    q_dest.push_back('0);
    cycle();
  endtask

  // Stale register values must be replaced by forwarding
  task automatic issue(input logic [31:0] exp_res, input logic exp_wr, input logic npc_v,
      input logic [31:0] npc, input logic stale_a, input logic stale_b);
    a_val = stale_a ? ~shadow[a_reg] : shadow[a_reg];
    b_val = stale_b ? ~shadow[b_reg] : shadow[b_reg];
    issue_valid = 1'b1;
    #1;
    check("new_pc_valid", new_pc_valid, npc_v);
    if (npc_v)
      check("new_pc", new_pc, npc);
    if (b_reg_valid)
      check("result_2", result_2, shadow[b_reg]);
    q_wr.push_back(exp_wr && dest_reg_valid);
    q_res.push_back(exp_res);
    q_dest.push_back(dest_reg);
    if (exp_wr && dest_reg_valid && dest_reg != 0)
      shadow[dest_reg] = exp_res;
    cycle();
    clear();
  endtask

  task automatic alu_instr(input alu_op_t op, input alu_res_t rs, input logic su,
      input logic [4:0] ra, input logic [4:0] rb, input logic use_imm, input logic [31:0] iv,
      input logic [4:0] sh, input logic av, input logic [4:0] rd, input logic sa, input logic sb);
    logic [31:0] a;
    logic [31:0] bf;
    logic [31:0] b;
    logic [31:0] exp;
    logic wr;
    a = shadow[ra];
    bf = shadow[rb];
    b = use_imm ? iv : bf;
    exp = model_alu(op, a, b, bf, av ? a[4:0] : sh, iv, rs == res_set, su);
    wr = (op == alu_movz) ? (b == 0) : (op == alu_movn) ? (b != 0) : 1'b1;
    alu_op = op;
    alu_res_sel = rs;
    alu_set_u = su;
    a_reg = ra;
    a_reg_valid = av;
    b_reg = rb;
    b_reg_valid = 1;
    imm = iv;
    imm_valid = use_imm;
    shamt = sh;
    dest_reg = rd;
    dest_reg_valid = 1;
    issue(exp, wr, 0, '0, sa, sb);
  endtask

  task automatic branch_instr(input logic jmp, input cond_t c, input logic [4:0] ra,
      input logic [4:0] rb, input logic use_imm);
    logic [31:0] a;
    logic [31:0] bf;
    logic [31:0] pc8;
    logic [31:0] target;
    logic taken;
    a = shadow[ra];
    bf = shadow[rb];
    pc8 = $random(seed);
    target = $random(seed);
    case (c)
      cond_eq: taken = (a == bf);
      cond_ne: taken = (a != bf);
      cond_gt: taken = $signed(a) > 0;
      cond_ge: taken = $signed(a) >= 0;
      cond_lt: taken = $signed(a) < 0;
      cond_le: taken = $signed(a) <= 0;
      default: taken = 1'b1;
    endcase
    jmp_inst = jmp;
    branch_inst = !jmp;
    branch_cond = c;
    a_reg = ra;
    a_reg_valid = 1;
    b_reg = rb;
    b_reg_valid = 1;
    imm = target;
    imm_valid = use_imm;
    pc_plus_8 = pc8;
    dest_reg = 5'd31;
    dest_reg_valid = 1;
    issue(pc8, 1, jmp || taken, use_imm ? target : a, 0, 0);
  endtask

  task automatic muldiv_instr(input muldiv_op_t mop, input logic u, input logic [4:0] ra,
      input logic [4:0] rb);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] qa;
    logic signed [31:0] qb;
    logic [63:0] p;
    a = shadow[ra];
    b = shadow[rb];
    sa = $signed(a);
    sb = $signed(b);
    qa = a;
    qb = b;
    p = u ? {32'b0, a} * {32'b0, b} : sa * sb;
    exp = '0;
    case (mop)
      md_mthi: hi_m = a;
      md_mtlo: lo_m = a;
      md_mfhi: exp = hi_m;
      md_mflo: exp = lo_m;
      md_mul: {hi_m, lo_m} = p;
      md_madd: {hi_m, lo_m} = {hi_m, lo_m} + p;
      md_div: begin
        if (b == 0) {hi_m, lo_m} = {a, 32'hffffffff};
        else if (u) {hi_m, lo_m} = {a % b, a / b};
        else {hi_m, lo_m} = {32'(qa % qb), 32'(qa / qb)};
      end
      default: exp = '0;
    endcase
    muldiv_op = mop;
    muldiv_u = u;
    a_reg = ra;
    a_reg_valid = 1;
    b_reg = rb;
    b_reg_valid = 1;
    dest_reg = pick_reg();
    dest_reg_valid = (mop == md_mfhi) || (mop == md_mflo);
    issue(exp, 1, 0, '0, 0, 0);
  endtask

  // A jump and an MTHI presented without issue_valid
  task automatic bubble_instr(input logic [4:0] ra);
    jmp_inst = 1'b1;
    muldiv_op = md_mthi;
    a_reg = ra;
    a_reg_valid = 1'b1;
    dest_reg = pick_reg();
    dest_reg_valid = 1'b1;
    a_val = shadow[ra];
    #1;
    check("new_pc_valid", new_pc_valid, 1'b0);
    q_wr.push_back(1'b0);
    q_res.push_back('0);
    q_dest.push_back('0);
    cycle();
    clear();
  endtask

  initial begin
    clear();
    a_val = '0;
    b_val = '0;
    hi_m = '0;
    lo_m = '0;
    cnt = 0;
    while (!reset_n && cnt < 50) begin
      @(posedge clock);
      cnt++;
    end
    if (!reset_n) begin
      $display("Reset was never released");
      $display("Test failed");
      $finish;
    end
    #1;
    check("ex_mem_valid", ex_mem_valid, 0);
    check("wb_valid", wb_valid, 0);
    shadow[0] = '0;
    for (int i = 1; i < 32; i++)
      shadow[i] = $random(seed);
    // Boundary operands that are never written
    shadow[28] = 32'h0;
    shadow[29] = 32'h7fffffff;
    shadow[30] = 32'h80000000;

    // Each operation in register form then immediate form
    for (int k = 0; k <= int'(alu_mul_lo); k++) begin
      alu_instr(alu_op_t'(k), res_alu, 0, pick_reg(), pick_reg(), 0, $random(seed),
                5'($random(seed)), 1, pick_reg(), 0, 0);
      if (!(alu_op_t'(k) inside {alu_movz, alu_movn}))
        alu_instr(alu_op_t'(k), res_alu, 0, pick_reg(), pick_reg(), 1, $random(seed),
                  5'($random(seed)), 0, pick_reg(), 0, 0);
    end

    for (int i = 0; i < 8; i++)
      alu_instr(alu_add, res_set, i[0], pick_reg(), pick_reg(), 0, '0, '0, 1, pick_reg(), 0, 0);
    for (int ra = 28; ra <= 30; ra++)
      for (int rb = 28; rb <= 30; rb++) begin
        alu_instr(alu_sub, res_set, 0, 5'(ra), 5'(rb), 0, '0, '0, 1, pick_reg(), 0, 0);
        alu_instr(alu_sub, res_set, 1, 5'(ra), 5'(rb), 0, '0, '0, 1, pick_reg(), 0, 0);
      end

    // Forwarding from EX/MEM, from MEM/WB, both, and r0
    alu_instr(alu_add, res_alu, 0, 2, 3, 0, '0, '0, 1, 1, 0, 0);
    alu_instr(alu_sub, res_alu, 0, 1, 5, 0, '0, '0, 1, 4, 1, 0);
    alu_instr(alu_add, res_alu, 0, 2, 3, 0, '0, '0, 1, 9, 0, 0);
    alu_instr(alu_xor, res_alu, 0, 5, 6, 0, '0, '0, 1, 10, 0, 0);
    alu_instr(alu_or, res_alu, 0, 5, 9, 0, '0, '0, 1, 11, 0, 1);
    alu_instr(alu_add, res_alu, 0, 2, 3, 0, '0, '0, 1, 12, 0, 0);
    alu_instr(alu_xor, res_alu, 0, 5, 6, 0, '0, '0, 1, 12, 0, 0);
    alu_instr(alu_add, res_alu, 0, 12, 12, 0, '0, '0, 1, 13, 1, 1);
    alu_instr(alu_add, res_alu, 0, 2, 3, 0, '0, '0, 1, 0, 0, 0);
    alu_instr(alu_add, res_alu, 0, 0, 2, 0, '0, '0, 1, 14, 0, 0);

    for (int u = 0; u < 2; u++) begin
      muldiv_instr(md_mul, u[0], pick_reg(), pick_reg());
      muldiv_instr(md_mfhi, u[0], 1, 1);
      muldiv_instr(md_mflo, u[0], 1, 1);
      muldiv_instr(md_madd, u[0], pick_reg(), pick_reg());
      muldiv_instr(md_madd, u[0], pick_reg(), pick_reg());
      muldiv_instr(md_mfhi, u[0], 1, 1);
      muldiv_instr(md_mflo, u[0], 1, 1);
      muldiv_instr(md_div, u[0], pick_reg(), pick_reg());
      muldiv_instr(md_mfhi, u[0], 1, 1);
      muldiv_instr(md_mflo, u[0], 1, 1);
      muldiv_instr(md_div, u[0], pick_reg(), 28);
      muldiv_instr(md_mfhi, u[0], 1, 1);
      muldiv_instr(md_mflo, u[0], 1, 1);
    end
    muldiv_instr(md_mthi, 0, pick_reg(), 1);
    muldiv_instr(md_mtlo, 0, pick_reg(), 1);
    muldiv_instr(md_mfhi, 0, 1, 1);
    muldiv_instr(md_mflo, 0, 1, 1);

    // HI and the PC stay put without issue_valid
    bubble_instr(29);
    muldiv_instr(md_mfhi, 0, 1, 1);

    // Taken then not taken for each condition
    branch_instr(0, cond_eq, 29, 29, 1);
    branch_instr(0, cond_eq, 29, 30, 1);
    branch_instr(0, cond_ne, 29, 30, 1);
    branch_instr(0, cond_ne, 28, 28, 1);
    branch_instr(0, cond_gt, 29, 1, 1);
    branch_instr(0, cond_gt, 28, 1, 1);
    branch_instr(0, cond_ge, 28, 1, 1);
    branch_instr(0, cond_ge, 30, 1, 1);
    branch_instr(0, cond_lt, 30, 1, 1);
    branch_instr(0, cond_lt, 28, 1, 1);
    branch_instr(0, cond_le, 28, 1, 1);
    branch_instr(0, cond_le, 29, 1, 1);
    branch_instr(0, cond_unconditional, 2, 1, 1);
    branch_instr(1, cond_unconditional, 2, 1, 1);
    branch_instr(1, cond_unconditional, 3, 1, 0);

    alu_instr(alu_movz, res_alu, 0, 2, 28, 0, '0, '0, 1, 15, 0, 0);
    alu_instr(alu_movz, res_alu, 0, 2, 29, 0, '0, '0, 1, 16, 0, 0);
    alu_instr(alu_movn, res_alu, 0, 3, 29, 0, '0, '0, 1, 17, 0, 0);
    alu_instr(alu_movn, res_alu, 0, 3, 28, 0, '0, '0, 1, 18, 0, 0);
    idle();
    idle();

    errors += ex_stage_inst.ex_stage_sva_inst.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("Timeout, the run did not reach its end");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Held for 8 rising edges
  initial begin
    reset_n = 1'b0;
    repeat (8) @(posedge clock);
    #1 reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: mips_ex.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/operand_forward.sv
rtl/alu.sv
rtl/hilo_unit.sv
rtl/branch_resolve.sv
rtl/result_pipe.sv
rtl/ex_stage.sv
bench/tb_clock_gen.sv
bench/ex_stage_sva.sv
bench/ex_stage_tb.sv

// File: rtl/alu.sv
`default_nettype none
`timescale 1ns/10ps

module alu import isa_pkg::*, pipe_pkg::*; (
  input  logic [data_width-1:0] op_a,
  input  logic [data_width-1:0] op_b,
  input  logic [data_width-1:0] b_forwarded,
  input  logic                  a_reg_valid,
  input  logic [4:0]            shamt,
  input  logic [data_width-1:0] imm,
  input  alu_op_t               alu_op,
  input  alu_res_t              alu_res_sel,
  input  logic                  alu_set_u,
  input  logic [data_width-1:0] mul_lo,
  output logic [data_width-1:0] alu_result,
  output logic                  b_is_zero
);

  logic [4:0]            shift_amt;
  logic [4:0]            field_lsb;
  logic [5:0]            field_size;
  logic [data_width-1:0] field_mask;
  logic [data_width-1:0] ins_mask;
  logic [data_width:0]   diff;
  logic                  set_lt;
  logic [data_width-1:0] alu_res;

  // Variable shifts take the amount from rs
  assign shift_amt = a_reg_valid ? op_a[4:0] : shamt;

  // imm[15:11] is msbd for EXT and msb for INS, imm[10:6] is lsb
  assign field_lsb  = imm[10:6];
  assign field_size = {1'b0, imm[15:11]} + 6'd1;
  assign field_mask = ~({data_width{1'b1}} << field_size);
  assign ins_mask   = field_mask & ({data_width{1'b1}} << field_lsb);

  assign diff = {1'b0, op_a} - {1'b0, op_b};

  // Borrow for unsigned, sign rule for signed
  assign set_lt = alu_set_u ? diff[data_width] :
                  (op_a[data_width-1] & ~op_b[data_width-1]) |
                  (diff[data_width-1] & ~(op_a[data_width-1] ^ op_b[data_width-1]));

  assign b_is_zero = (op_b == '0);

  always_comb begin
    alu_res = '0;
    case (alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = diff[data_width-1:0];
      alu_or:     alu_res = op_a | op_b;
      alu_xor:    alu_res = op_a ^ op_b;
      alu_nor:    alu_res = ~(op_a | op_b);
      alu_and:    alu_res = op_a & op_b;
      alu_pass_a: alu_res = op_a;
      alu_pass_b: alu_res = op_b;
      alu_sll:    alu_res = op_b << shift_amt;
      alu_srl:    alu_res = op_b >> shift_amt;
      alu_sra:    alu_res = $signed(op_b) >>> shift_amt;
      alu_lui:    alu_res = {op_b[15:0], 16'b0};
      alu_movz:   alu_res = op_a;
      alu_movn:   alu_res = op_a;
      alu_seb:    alu_res = {{24{op_b[7]}}, op_b[7:0]};
      alu_seh:    alu_res = {{16{op_b[15]}}, op_b[15:0]};
      alu_ext:    alu_res = (op_a >> field_lsb) & field_mask;
      // Old rt bits kept outside the field
      alu_ins:    alu_res = (b_forwarded & ~ins_mask) | ((op_a << field_lsb) & ins_mask);
      alu_mul_lo: alu_res = mul_lo;
      default:    alu_res = '0;
    endcase
  end

  assign alu_result = (alu_res_sel == res_alu) ? alu_res : {{(data_width-1){1'b0}}, set_lt};

endmodule

`default_nettype wire

// File: rtl/branch_resolve.sv
`default_nettype none
`timescale 1ns/10ps

module branch_resolve import isa_pkg::*, pipe_pkg::*; (
  input  logic                  issue_valid,
  input  logic [data_width-1:0] op_a,
  input  logic [data_width-1:0] b_forwarded,
  input  logic [data_width-1:0] imm,
  input  logic                  imm_valid,
  input  logic                  jmp_inst,
  input  logic                  branch_inst,
  input  cond_t                 branch_cond,
  output logic [data_width-1:0] new_pc,
  output logic                  new_pc_valid
);

  logic a_eq_b;
  logic a_gez;
  logic a_gtz;
  logic cond_ok;

  // Forwarded B since the immediate carries the target
  assign a_eq_b = (op_a == b_forwarded);
  assign a_gez  = ~op_a[data_width-1];
  assign a_gtz  = a_gez && (op_a != '0);

  always_comb begin
    case (branch_cond)
      cond_unconditional: cond_ok = 1'b1;
      cond_eq:            cond_ok = a_eq_b;
      cond_ne:            cond_ok = ~a_eq_b;
      cond_gt:            cond_ok = a_gtz;
      cond_ge:            cond_ok = a_gez;
      cond_lt:            cond_ok = ~a_gez;
      cond_le:            cond_ok = ~a_gtz;
      default:            cond_ok = 1'b0;
    endcase
  end

  assign new_pc       = imm_valid ? imm : op_a;
  assign new_pc_valid = issue_valid && (jmp_inst || (branch_inst && cond_ok));

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
`default_nettype none
`timescale 1ns/10ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic                     issue_valid,
  input  alu_op_t                  alu_op,
  input  alu_res_t                 alu_res_sel,
  input  logic                     alu_set_u,
  input  muldiv_op_t               muldiv_op,
  input  logic                     muldiv_u,
  input  logic                     jmp_inst,
  input  logic                     branch_inst,
  input  cond_t                    branch_cond,
  input  logic [data_width-1:0]    imm,
  input  logic                     imm_valid,
  input  logic [4:0]               shamt,
  input  logic [reg_idx_width-1:0] a_reg,
  input  logic                     a_reg_valid,
  input  logic [reg_idx_width-1:0] b_reg,
  input  logic                     b_reg_valid,
  input  logic [data_width-1:0]    a_val,
  input  logic [data_width-1:0]    b_val,
  input  logic [reg_idx_width-1:0] dest_reg,
  input  logic                     dest_reg_valid,
  input  logic [data_width-1:0]    pc_plus_8,
  output logic [data_width-1:0]    new_pc,
  output logic                     new_pc_valid,
  output logic [data_width-1:0]    result_2,
  output logic [data_width-1:0]    ex_mem_result,
  output logic [reg_idx_width-1:0] ex_mem_dest,
  output logic                     ex_mem_valid,
  output logic [data_width-1:0]    wb_result,
  output logic [reg_idx_width-1:0] wb_dest,
  output logic                     wb_valid
);

  logic [data_width-1:0] op_a;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] b_forwarded;
  logic [data_width-1:0] alu_result;
  logic                  b_is_zero;
  logic [data_width-1:0] hi;
  logic [data_width-1:0] lo;
  logic [data_width-1:0] mul_lo;
  logic [data_width-1:0] ex_result;
  logic                  mov_cancel;
  logic                  ex_write;

  operand_forward operand_forward_inst (.*);

  alu alu_inst (.*);

  hilo_unit hilo_unit_inst (.*);

  branch_resolve branch_resolve_inst (.*);

  // Link address for jumps and branches
  assign ex_result = (jmp_inst || branch_inst) ? pc_plus_8  :
                     (muldiv_op == md_mfhi)    ? hi         :
                     (muldiv_op == md_mflo)    ? lo         :
                                                 alu_result;

  // MOVZ/MOVN drop the write when the test on rt fails
  assign mov_cancel = ((alu_op == alu_movz) && !b_is_zero) ||
                      ((alu_op == alu_movn) && b_is_zero);
  assign ex_write   = issue_valid && dest_reg_valid && !mov_cancel;

  // Store data path
  assign result_2 = b_forwarded;

  result_pipe result_pipe_inst (
    .clock         (clock),
    .reset_n       (reset_n),
    .ex_result     (ex_result),
    .ex_dest       (dest_reg),
    .ex_write      (ex_write),
    .ex_mem_result (ex_mem_result),
    .ex_mem_dest   (ex_mem_dest),
    .ex_mem_valid  (ex_mem_valid),
    .wb_result     (wb_result),
    .wb_dest       (wb_dest),
    .wb_valid      (wb_valid)
  );

endmodule

`default_nettype wire

// File: rtl/hilo_unit.sv
`default_nettype none
`timescale 1ns/10ps

module hilo_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  issue_valid,
  input  muldiv_op_t            muldiv_op,
  input  logic                  muldiv_u,
  input  logic [data_width-1:0] op_a,
  input  logic [data_width-1:0] op_b,
  output logic [data_width-1:0] hi,
  output logic [data_width-1:0] lo,
  output logic [data_width-1:0] mul_lo
);

  logic        [2*data_width-1:0] prod_u;
  logic signed [2*data_width-1:0] prod_s;
  logic        [2*data_width-1:0] product;
  logic        [data_width-1:0]   quot;
  logic        [data_width-1:0]   rem;
  logic        [data_width-1:0]   next_hi;
  logic        [data_width-1:0]   next_lo;
  logic                           load_hi;
  logic                           load_lo;

  assign prod_u  = {{data_width{1'b0}}, op_a} * {{data_width{1'b0}}, op_b};
  assign prod_s  = $signed(op_a) * $signed(op_b);
  assign product = muldiv_u ? prod_u : prod_s;
  assign mul_lo  = product[data_width-1:0];

  // Divide by zero gives all ones and keeps the dividend
  always_comb begin
    if (op_b == '0) begin
      quot = '1;
      rem  = op_a;
    end else if (muldiv_u) begin
      quot = op_a / op_b;
      rem  = op_a % op_b;
    end else begin
      quot = $signed(op_a) / $signed(op_b);
      rem  = $signed(op_a) % $signed(op_b);
    end
  end

  always_comb begin
    next_hi = op_a;
    next_lo = op_a;
    case (muldiv_op)
      md_mul:  {next_hi, next_lo} = product;
      md_madd: {next_hi, next_lo} = {hi, lo} + product;
      md_div: begin
        next_hi = rem;
        next_lo = quot;
      end
      default: begin
      end
    endcase
  end

  assign load_hi = issue_valid && (muldiv_op inside {md_mthi, md_mul, md_madd, md_div});
  assign load_lo = issue_valid && (muldiv_op inside {md_mtlo, md_mul, md_madd, md_div});

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      hi <= '0;
      lo <= '0;
    end else begin
      if (load_hi)
        hi <= next_hi;
      if (load_lo)
        lo <= next_lo;
    end
  end

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // ALU operations
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_or,
    alu_xor,
    alu_nor,
    alu_and,
    alu_pass_a,
    alu_pass_b,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui,
    alu_movz,
    alu_movn,
    alu_seb,
    alu_seh,
    alu_ext,
    alu_ins,
    alu_mul_lo
  } alu_op_t;

  // Stage result select
  typedef enum logic {
    res_alu,
    res_set
  } alu_res_t;

  // HI/LO operations
  typedef enum logic [2:0] {
    md_none,
    md_mthi,
    md_mtlo,
    md_mfhi,
    md_mflo,
    md_mul,
    md_madd,
    md_div
  } muldiv_op_t;

  // Branch conditions
  typedef enum logic [2:0] {
    cond_unconditional,
    cond_eq,
    cond_ne,
    cond_gt,
    cond_ge,
    cond_lt,
    cond_le
  } cond_t;

endpackage

`default_nettype wire

// File: rtl/operand_forward.sv
`default_nettype none
`timescale 1ns/10ps

module operand_forward import isa_pkg::*, pipe_pkg::*; (
  input  logic [data_width-1:0]    a_val,
  input  logic [data_width-1:0]    b_val,
  input  logic [reg_idx_width-1:0] a_reg,
  input  logic                     a_reg_valid,
  input  logic [reg_idx_width-1:0] b_reg,
  input  logic                     b_reg_valid,
  input  logic [data_width-1:0]    imm,
  input  logic                     imm_valid,
  input  logic [data_width-1:0]    ex_mem_result,
  input  logic [reg_idx_width-1:0] ex_mem_dest,
  input  logic                     ex_mem_valid,
  input  logic [data_width-1:0]    wb_result,
  input  logic [reg_idx_width-1:0] wb_dest,
  input  logic                     wb_valid,
  output logic [data_width-1:0]    op_a,
  output logic [data_width-1:0]    op_b,
  output logic [data_width-1:0]    b_forwarded
);

  logic a_hit_ex_mem;
  logic a_hit_wb;
  logic b_hit_ex_mem;
  logic b_hit_wb;

  // r0 is hardwired to zero and never forwarded
  assign a_hit_ex_mem = ex_mem_valid && a_reg_valid && (a_reg == ex_mem_dest) && (a_reg != '0);
  assign a_hit_wb     = wb_valid && a_reg_valid && (a_reg == wb_dest) && (a_reg != '0);
  assign b_hit_ex_mem = ex_mem_valid && b_reg_valid && (b_reg == ex_mem_dest) && (b_reg != '0);
  assign b_hit_wb     = wb_valid && b_reg_valid && (b_reg == wb_dest) && (b_reg != '0);

  // Newest result wins
  assign op_a = a_hit_ex_mem ? ex_mem_result :
                a_hit_wb     ? wb_result     :
                               a_val;

  assign b_forwarded = b_hit_ex_mem ? ex_mem_result :
                       b_hit_wb     ? wb_result     :
                                      b_val;

  assign op_b = imm_valid ? imm : b_forwarded;

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // One machine word
  localparam int data_width = 32;

  // 32 architectural registers
  localparam int reg_idx_width = 5;

endpackage

`default_nettype wire

// File: rtl/result_pipe.sv
`default_nettype none
`timescale 1ns/10ps

module result_pipe import isa_pkg::*, pipe_pkg::*; (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic [data_width-1:0]    ex_result,
  input  logic [reg_idx_width-1:0] ex_dest,
  input  logic                     ex_write,
  output logic [data_width-1:0]    ex_mem_result,
  output logic [reg_idx_width-1:0] ex_mem_dest,
  output logic                     ex_mem_valid,
  output logic [data_width-1:0]    wb_result,
  output logic [reg_idx_width-1:0] wb_dest,
  output logic                     wb_valid
);

  // Valid bits
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ex_mem_valid <= 1'b0;
      wb_valid     <= 1'b0;
    end else begin
      ex_mem_valid <= ex_write;
      wb_valid     <= ex_mem_valid;
    end
  end

  // Payload moves every cycle
  always_ff @(posedge clock) begin
    ex_mem_result <= ex_result;
    ex_mem_dest   <= ex_dest;
    wb_result     <= ex_mem_result;
    wb_dest       <= ex_mem_dest;
  end

endmodule

`default_nettype wire
